//--- src/fma16_defines.svh
// fma16 format constants
// binary16 field widths, exponent bias, working vector widths and
// the fixed encodings used for special results
`ifndef FMA16_DEFINES_SVH
`define FMA16_DEFINES_SVH

`define FMA_EXP_W       5           // exponent field
`define FMA_MAN_W       10          // stored mantissa, hidden one not counted
`define FMA_BIAS        15
`define FMA_PROD_W      22          // 11 x 11 bit mantissa product

// product, left shifted addend, guard room and a carry bit
`define FMA_SUM_W       48

`define FMA_QNAN        16'h7e00    // canonical quiet nan
`define FMA_MAX_FINITE  16'h7bff    // 65504

`endif

//--- src/fma16_pkg.sv
// fma16 shared types
// half-precision words and fields, working widths, rounding modes
// and the handshake controller states
`include "fma16_defines.svh"

package fma16_pkg;

    typedef logic [`FMA_EXP_W+`FMA_MAN_W:0] fp16_t;      // sign, exponent, mantissa
    typedef logic [`FMA_EXP_W-1:0]          exp_t;       // biased exponent field
    typedef logic [`FMA_MAN_W-1:0]          man_t;
    typedef logic signed [7:0]              exp_ext_t;   // working exponent, can go negative
    typedef logic [`FMA_PROD_W-1:0]         prod_man_t;
    typedef logic [`FMA_SUM_W-1:0]          sum_man_t;
    typedef logic [3:0]                     fp_flags_t;  // invalid, overflow, underflow, inexact
    typedef logic [1:0]                     round_mode_t;

    //////////////////////////////////////////////////
    // rounding mode encodings
    //////////////////////////////////////////////////
    localparam round_mode_t RM_RZ  = 2'b00;  // toward zero
    localparam round_mode_t RM_RNE = 2'b01;  // nearest, ties to even
    localparam round_mode_t RM_RDN = 2'b10;  // toward -inf
    localparam round_mode_t RM_RUP = 2'b11;  // toward +inf

    // four-phase handshake controller
    typedef enum logic [1:0] {
        HS_IDLE,     // ready for a new item
        HS_BUSY,     // req/ack high, waiting on the far side
        HS_RELEASE   // return-to-zero phase
    } hs_state_t;

endpackage

//--- src/fma_unpack_stage.sv
// fma16 unpack stage
// input four-phase handshake, operand split and classification
// resolves the opcode and decides nan / infinity results up front
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma_unpack_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,          // hold from the round stage
    input  fma16_pkg::fp16_t       x,
    input  fma16_pkg::fp16_t       y,
    input  fma16_pkg::fp16_t       z,
    input  logic                   mul,            // multiply only, z ignored
    input  logic                   add,            // add only, y ignored
    input  logic                   negp,
    input  logic                   negz,
    input  fma16_pkg::round_mode_t roundmode,
    input  logic                   in_req,
    output logic                   in_ack,
    output logic                   u_valid,
    output logic                   u_xs, u_ys, u_zs,
    output fma16_pkg::exp_t        u_xe, u_ye, u_ze,
    output fma16_pkg::man_t        u_xm, u_ym, u_zm,
    output logic                   u_x_zero, u_y_zero, u_z_zero,
    output fma16_pkg::round_mode_t u_mode,
    output logic                   u_special,
    output fma16_pkg::fp16_t       u_special_res,
    output fma16_pkg::fp_flags_t   u_special_flags
);
    import fma16_pkg::*;

    hs_state_t state;
    logic      capture;
    fp16_t     y_op, z_op;          // operands after the opcode is applied
    logic      ps;                  // signed product sign
    logic      x_nan, x_inf, x_zero;
    logic      y_nan, y_inf, y_zero;
    logic      z_nan, z_inf, z_zero;
    logic      snan, p_inf;
    logic      special;
    fp16_t     special_res;
    fp_flags_t special_flags;

    // {nan, inf, zero}, subnormals count as zero
    function automatic logic [2:0] classify(input fp16_t v);
        logic exp_max;
        exp_max = &v[14:10];
        return {exp_max & |v[9:0], exp_max & ~|v[9:0], ~|v[14:10]};
    endfunction

    //////////////////////////////////////////////////
    // input handshake
    //////////////////////////////////////////////////
    assign capture = in_req & ~in_ack & (state == HS_IDLE) & ~stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= HS_IDLE;
            in_ack <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: if (capture) begin
                    in_ack <= 1'b1;
                    state  <= HS_BUSY;
                end
                HS_BUSY: if (!in_req) begin
                    in_ack <= 1'b0;          // req seen low, drop ack
                    state  <= HS_RELEASE;
                end
                default: state <= HS_IDLE;  // one dead cycle before the next capture
            endcase
        end
    end

    // opcode: add makes y = +1.0, mul makes z a zero of the product's sign
    assign y_op = add ? {1'b0, exp_t'(`FMA_BIAS), man_t'(0)} : y;
    assign ps   = x[15] ^ y_op[15] ^ negp;
    assign z_op = mul ? {ps, 15'b0} : {z[15] ^ negz, z[14:0]};

    assign {x_nan, x_inf, x_zero} = classify(x);
    assign {y_nan, y_inf, y_zero} = classify(y_op);
    assign {z_nan, z_inf, z_zero} = classify(z_op);

    // signaling nan has the mantissa top bit clear
    assign snan  = (x_nan & ~x[9]) | (y_nan & ~y_op[9]) | (z_nan & ~z_op[9]);
    assign p_inf = x_inf | y_inf;

    always_comb begin
        special       = 1'b1;
        special_res   = `FMA_QNAN;
        special_flags = 4'b0000;
        if (x_nan | y_nan | z_nan)
            special_flags = {snan, 3'b000};
        else if ((x_inf & y_zero) | (y_inf & x_zero))
            special_flags = 4'b1000;                   // inf * 0
        else if (p_inf & z_inf & (ps != z_op[15]))
            special_flags = 4'b1000;                   // inf - inf
        else if (p_inf)
            special_res = {ps, 5'h1f, 10'h000};
        else if (z_inf)
            special_res = {z_op[15], 5'h1f, 10'h000};
        else
            special = 1'b0;                            // finite, computed downstream
    end

    always_ff @(posedge clk) begin
        if (reset)
            u_valid <= 1'b0;
        else if (!stall)
            u_valid <= capture;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            u_xs            <= x[15] ^ negp;           // negp folded into x
            u_ys            <= y_op[15];
            u_zs            <= z_op[15];
            u_xe            <= x[14:10];
            u_ye            <= y_op[14:10];
            u_ze            <= z_op[14:10];
            u_xm            <= x[9:0];
            u_ym            <= y_op[9:0];
            u_zm            <= z_op[9:0];
            u_x_zero        <= x_zero;
            u_y_zero        <= y_zero;
            u_z_zero        <= z_zero;
            u_mode          <= roundmode;
            u_special       <= special;
            u_special_res   <= special_res;
            u_special_flags <= special_flags;
        end
    end

    // once the source has dropped req for two edges the ack must be gone
    a_ack_release: assert property (@(posedge clk) disable iff (reset)
        (!in_req && $past(!in_req)) |-> !in_ack);

endmodule

//--- src/fma_product_stage.sv
// fma16 product stage
// product sign, biased product exponent and the 22-bit mantissa product
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma_product_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   u_valid,
    input  logic                   u_xs, u_ys, u_zs,
    input  fma16_pkg::exp_t        u_xe, u_ye, u_ze,
    input  fma16_pkg::man_t        u_xm, u_ym, u_zm,
    input  logic                   u_x_zero, u_y_zero, u_z_zero,
    input  fma16_pkg::round_mode_t u_mode,
    input  logic                   u_special,
    input  fma16_pkg::fp16_t       u_special_res,
    input  fma16_pkg::fp_flags_t   u_special_flags,
    output logic                   p_valid,
    output logic                   p_sign,
    output fma16_pkg::exp_ext_t    p_exp,          // biased, may leave 1..30
    output fma16_pkg::prod_man_t   p_man,
    output logic                   p_zero,
    output logic                   p_zs,
    output fma16_pkg::exp_t        p_ze,
    output fma16_pkg::man_t        p_zm,
    output logic                   p_z_zero,
    output fma16_pkg::round_mode_t p_mode,
    output logic                   p_special,
    output fma16_pkg::fp16_t       p_special_res,
    output fma16_pkg::fp_flags_t   p_special_flags
);
    import fma16_pkg::*;

    always_ff @(posedge clk) begin
        if (reset)
            p_valid <= 1'b0;
        else if (!stall)
            p_valid <= u_valid;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            p_sign          <= u_xs ^ u_ys;
            p_exp           <= exp_ext_t'(u_xe) + exp_ext_t'(u_ye) - exp_ext_t'(`FMA_BIAS);
            p_man           <= {1'b1, u_xm} * {1'b1, u_ym};   // hidden ones restored
            p_zero          <= u_x_zero | u_y_zero;
            p_zs            <= u_zs;                           // addend rides along
            p_ze            <= u_ze;
            p_zm            <= u_zm;
            p_z_zero        <= u_z_zero;
            p_mode          <= u_mode;
            p_special       <= u_special;
            p_special_res   <= u_special_res;
            p_special_flags <= u_special_flags;
        end
    end

endmodule

//--- src/fma_sum_stage.sv
// fma16 sum stage
// aligns the smaller of product and addend under the larger one,
// adds or subtracts magnitudes and keeps the shifted-out bits as sticky
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma_sum_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   p_valid,
    input  logic                   p_sign,
    input  fma16_pkg::exp_ext_t    p_exp,
    input  fma16_pkg::prod_man_t   p_man,
    input  logic                   p_zero,
    input  logic                   p_zs,
    input  fma16_pkg::exp_t        p_ze,
    input  fma16_pkg::man_t        p_zm,
    input  logic                   p_z_zero,
    input  fma16_pkg::round_mode_t p_mode,
    input  logic                   p_special,
    input  fma16_pkg::fp16_t       p_special_res,
    input  fma16_pkg::fp_flags_t   p_special_flags,
    output logic                   s_valid,
    output logic                   s_sign,
    output fma16_pkg::exp_ext_t    s_exp,          // exponent of bit SUM_W-3
    output fma16_pkg::sum_man_t    s_man,
    output logic                   s_sticky,
    output logic                   s_zero,
    output fma16_pkg::round_mode_t s_mode,
    output logic                   s_special,
    output fma16_pkg::fp16_t       s_special_res,
    output fma16_pkg::fp_flags_t   s_special_flags
);
    import fma16_pkg::*;

    localparam int LOW = `FMA_SUM_W - `FMA_PROD_W - 1;  // guard room under the big operand

    exp_ext_t  z_exp, big_exp, diff;
    prod_man_t p_op, z_op, big_op, small_op;
    logic      prod_big, big_sign, small_sign, sub, sticky, sign, zero_sign;
    sum_man_t  a, b, mag;
    logic [2*`FMA_SUM_W-1:0] small_wide;

    // both operands as 22 bits with bit 20 worth 2^exp and zeros dropped
    assign z_exp    = exp_ext_t'(p_ze);
    assign p_op     = p_zero ? '0 : p_man;
    assign z_op     = p_z_zero ? '0 : {2'b01, p_zm, man_t'(0)};

    assign prod_big   = p_z_zero | (~p_zero & (p_exp >= z_exp));
    assign big_exp    = prod_big ? p_exp : z_exp;
    assign diff       = prod_big ? p_exp - z_exp : z_exp - p_exp;
    assign big_op     = prod_big ? p_op : z_op;
    assign small_op   = prod_big ? z_op : p_op;
    assign big_sign   = prod_big ? p_sign : p_zs;
    assign small_sign = prod_big ? p_zs : p_sign;

    //////////////////////////////////////////////////
    // alignment
    //////////////////////////////////////////////////
    assign a          = sum_man_t'(big_op) << LOW;
    assign small_wide = {sum_man_t'(small_op) << LOW, sum_man_t'(0)} >> diff[6:0];
    assign b          = small_wide[2*`FMA_SUM_W-1:`FMA_SUM_W];
    assign sticky     = |small_wide[`FMA_SUM_W-1:0];       // bits past the end

    assign sub = p_sign ^ p_zs;

    always_comb begin
        if (!sub) begin
            mag  = a + b;
            sign = big_sign;
        end else if (b > a) begin
            mag  = b - a;                                  // only without sticky
            sign = small_sign;
        end else begin
            mag  = a - b - sum_man_t'(sticky);             // borrow for the lost tail
            sign = big_sign;
        end
    end

    // an exact zero is -0 for two negative terms or for unlike signs in round-down
    assign zero_sign = (p_sign & p_zs) | (sub & (p_mode == RM_RDN));

    always_ff @(posedge clk) begin
        if (reset)
            s_valid <= 1'b0;
        else if (!stall)
            s_valid <= p_valid;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s_sign          <= (mag == '0) ? zero_sign : sign;
            s_exp           <= big_exp;
            s_man           <= mag;
            s_sticky        <= sticky;
            s_zero          <= (mag == '0);
            s_mode          <= p_mode;
            s_special       <= p_special;
            s_special_res   <= p_special_res;
            s_special_flags <= p_special_flags;
        end
    end

    // a lost tail never comes with a zero sum or with a carry out
    a_zero_clean: assert property (@(posedge clk) disable iff (reset)
        (s_valid && (s_zero || s_man[`FMA_SUM_W-1])) |-> !s_sticky);

endmodule

//--- src/fma_round_stage.sv
// fma16 round stage
// leading-one normalize, round per mode, overflow / flush to zero,
// special result select and the output four-phase handshake
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma_round_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   out_ack,
    input  logic                   s_valid,
    input  logic                   s_sign,
    input  fma16_pkg::exp_ext_t    s_exp,
    input  fma16_pkg::sum_man_t    s_man,
    input  logic                   s_sticky,
    input  logic                   s_zero,
    input  fma16_pkg::round_mode_t s_mode,
    input  logic                   s_special,
    input  fma16_pkg::fp16_t       s_special_res,
    input  fma16_pkg::fp_flags_t   s_special_flags,
    output logic                   stall,          // shared pipeline hold
    output logic                   out_req,
    output fma16_pkg::fp16_t       result,
    output fma16_pkg::fp_flags_t   flags
);
    import fma16_pkg::*;

    localparam int TOP   = `FMA_SUM_W - 3;                 // bit weighted 2^s_exp
    localparam int GUARD = `FMA_SUM_W - `FMA_MAN_W - 2;    // first bit below the lsb

    hs_state_t state;
    logic [5:0] lead;                 // leading one position
    sum_man_t   norm;
    exp_ext_t   e_pre, e_fin;
    logic       lsb, guard, sticky_all, inexact, up, to_inf, ovf, unf;
    logic [11:0] rnd;                 // rounded 1.m plus carry
    man_t       mant;
    fp16_t      next_result;
    fp_flags_t  next_flags;

    //////////////////////////////////////////////////
    // normalize
    //////////////////////////////////////////////////
    always_comb begin
        lead = '0;
        for (int i = 0; i < `FMA_SUM_W; i++)
            if (s_man[i])
                lead = 6'(i);
    end

    assign norm       = s_man << (6'(`FMA_SUM_W - 1) - lead);   // leading one to the top
    assign e_pre      = s_exp + exp_ext_t'(lead) - exp_ext_t'(TOP);
    assign lsb        = norm[GUARD+1];
    assign guard      = norm[GUARD];
    assign sticky_all = |norm[GUARD-1:0] | s_sticky;
    assign inexact    = guard | sticky_all;

    always_comb begin
        case (s_mode)
            RM_RZ:   up = 1'b0;
            RM_RNE:  up = guard & (sticky_all | lsb);
            RM_RDN:  up = s_sign & inexact;
            default: up = ~s_sign & inexact;       // toward +inf
        endcase
    end

    assign rnd   = {1'b0, norm[`FMA_SUM_W-1:GUARD+1]} + 12'(up);
    assign mant  = rnd[11] ? rnd[10:1] : rnd[9:0];            // carry renormalizes
    assign e_fin = e_pre + exp_ext_t'(rnd[11]);
    assign ovf   = e_fin >= exp_ext_t'({`FMA_EXP_W{1'b1}});
    assign unf   = e_pre <= 0;                                // exact value below min normal

    // overflow goes to infinity unless the mode rounds toward zero here
    assign to_inf = (s_mode == RM_RNE) | ((s_mode == RM_RUP) & ~s_sign)
                  | ((s_mode == RM_RDN) & s_sign);

    always_comb begin
        if (s_special) begin
            next_result = s_special_res;
            next_flags  = s_special_flags;
        end else if (s_zero) begin
            next_result = {s_sign, 15'b0};
            next_flags  = 4'b0000;
        end else if (unf) begin
            next_result = {s_sign, 15'b0};                    // flush
            next_flags  = 4'b0011;
        end else if (ovf) begin
            next_result = to_inf ? {s_sign, 5'h1f, 10'h000}
                                 : {s_sign, 15'(`FMA_MAX_FINITE)};
            next_flags  = 4'b0101;
        end else begin
            next_result = {s_sign, e_fin[4:0], mant};
            next_flags  = {3'b000, inexact};
        end
    end

    //////////////////////////////////////////////////
    // output handshake
    //////////////////////////////////////////////////
    assign stall = s_valid & (state != HS_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= HS_IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: if (s_valid) begin
                    out_req <= 1'b1;
                    state   <= HS_BUSY;
                end
                HS_BUSY: if (out_ack) begin
                    out_req <= 1'b0;
                    state   <= HS_RELEASE;
                end
                default: if (!out_ack)
                    state <= HS_IDLE;       // sink has returned to zero
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == HS_IDLE && s_valid) begin
            result <= next_result;
            flags  <= next_flags;
        end
    end

    // result holds for the whole request phase
    a_result_hold: assert property (@(posedge clk) disable iff (reset)
        (out_req && !out_ack) |=> ($stable(result) && $stable(flags)));

endmodule

//--- src/fma16_top.sv
// fma16 top
// four-stage pipelined half-precision fused multiply-add
// four-phase req/ack at input and output, one shared stall
`timescale 1ns/10ps

module fma16_top (
    input  logic                   clk,
    input  logic                   reset,
    input  fma16_pkg::fp16_t       x,
    input  fma16_pkg::fp16_t       y,
    input  fma16_pkg::fp16_t       z,
    input  logic                   mul,
    input  logic                   add,
    input  logic                   negp,
    input  logic                   negz,
    input  fma16_pkg::round_mode_t roundmode,
    input  logic                   in_req,
    output logic                   in_ack,
    output fma16_pkg::fp16_t       result,
    output fma16_pkg::fp_flags_t   flags,
    output logic                   out_req,
    input  logic                   out_ack
);
    import fma16_pkg::*;

    logic        stall;

    // unpack -> product
    logic        u_valid;
    logic        u_xs, u_ys, u_zs;
    exp_t        u_xe, u_ye, u_ze;
    man_t        u_xm, u_ym, u_zm;
    logic        u_x_zero, u_y_zero, u_z_zero;
    round_mode_t u_mode;
    logic        u_special;
    fp16_t       u_special_res;
    fp_flags_t   u_special_flags;

    // product -> sum
    logic        p_valid, p_sign, p_zero;
    exp_ext_t    p_exp;
    prod_man_t   p_man;
    logic        p_zs, p_z_zero;
    exp_t        p_ze;
    man_t        p_zm;
    round_mode_t p_mode;
    logic        p_special;
    fp16_t       p_special_res;
    fp_flags_t   p_special_flags;

    // sum -> round
    logic        s_valid, s_sign, s_sticky, s_zero;
    exp_ext_t    s_exp;
    sum_man_t    s_man;
    round_mode_t s_mode;
    logic        s_special;
    fp16_t       s_special_res;
    fp_flags_t   s_special_flags;

    // stage ports share their names with these nets
    fma_unpack_stage  u_unpack  (.*);
    fma_product_stage u_product (.*);
    fma_sum_stage     u_sum     (.*);
    fma_round_stage   u_round   (.*);

endmodule

//--- tests/fma16_ref.svh
// fma16 reference model
// exact fused multiply-add on half-precision operands, product and addend
// become scaled integers, the exact sum is normalized and rounded once
`ifndef FMA16_REF_SVH
`define FMA16_REF_SVH
`include "fma16_defines.svh"

function automatic void fma16_ref(
    input  fp16_t       a,
    input  fp16_t       b,
    input  fp16_t       c,
    input  logic        op_mul,
    input  logic        op_add,
    input  logic        op_negp,
    input  logic        op_negz,
    input  round_mode_t mode,
    output fp16_t       res,
    output fp_flags_t   flg
);
    fp16_t        bb, cc;                  // operands after the opcode
    logic         ps;                      // signed product sign
    logic         a_nan, b_nan, c_nan, a_inf, b_inf, c_inf, a_zero, b_zero, c_zero;
    logic         rsign, inexact, up, to_inf;
    logic [127:0] pm, zm, mag, keep, rest, half;
    int           pe, ze, e_lo, lead, sh, be;

    bb = op_add ? {1'b0, 5'(`FMA_BIAS), 10'h000} : b;   // add only: y = +1.0
    ps = a[15] ^ bb[15] ^ op_negp;
    cc = op_mul ? {ps, 15'h0000} : {c[15] ^ op_negz, c[14:0]};

    // exponent field 0 counts as zero, subnormals too
    a_nan  = (a[14:10] == 5'h1f) && (a[9:0] != 0);
    b_nan  = (bb[14:10] == 5'h1f) && (bb[9:0] != 0);
    c_nan  = (cc[14:10] == 5'h1f) && (cc[9:0] != 0);
    a_inf  = (a[14:10] == 5'h1f) && (a[9:0] == 0);
    b_inf  = (bb[14:10] == 5'h1f) && (bb[9:0] == 0);
    c_inf  = (cc[14:10] == 5'h1f) && (cc[9:0] == 0);
    a_zero = (a[14:10] == 0);
    b_zero = (bb[14:10] == 0);
    c_zero = (cc[14:10] == 0);

    res = `FMA_QNAN;
    flg = 4'b0000;
    if (a_nan || b_nan || c_nan) begin
        flg[3] = (a_nan & ~a[9]) | (b_nan & ~bb[9]) | (c_nan & ~cc[9]);  // signaling only
        return;
    end
    if ((a_inf && b_zero) || (b_inf && a_zero) || ((a_inf || b_inf) && c_inf && ps != cc[15])) begin
        flg = 4'b1000;
        return;
    end
    if (a_inf || b_inf) begin
        res = {ps, 5'h1f, 10'h000};
        return;
    end
    if (c_inf) begin
        res = {cc[15], 5'h1f, 10'h000};
        return;
    end

    //////////////////////////////////////////////////
    // exact sum as integer times 2^e_lo
    //////////////////////////////////////////////////
    pm   = (a_zero || b_zero) ? 128'd0 : 128'({1'b1, a[9:0]}) * 128'({1'b1, bb[9:0]});
    zm   = c_zero ? 128'd0 : 128'({1'b1, cc[9:0]});
    pe   = int'(a[14:10]) + int'(bb[14:10]) - 2 * (`FMA_BIAS + `FMA_MAN_W);  // lsb weight
    ze   = int'(cc[14:10]) - (`FMA_BIAS + `FMA_MAN_W);
    e_lo = (pe < ze) ? pe : ze;
    pm   = pm << (pe - e_lo);
    zm   = zm << (ze - e_lo);

    if (ps == cc[15]) begin
        mag   = pm + zm;
        rsign = ps;
    end else if (pm >= zm) begin
        mag   = pm - zm;
        rsign = ps;
    end else begin
        mag   = zm - pm;
        rsign = cc[15];
    end
    if (mag == 0) begin       // -0 only for two negative terms, or unlike signs in round-down
        res = {(ps & cc[15]) | ((ps != cc[15]) & (mode == RM_RDN)), 15'h0000};
        return;
    end

    lead = 0;
    for (int i = 0; i < 128; i++)
        if (mag[i])
            lead = i;
    be = lead + e_lo + `FMA_BIAS;              // biased exponent of the exact value
    if (be <= 0) begin
        res = {rsign, 15'h0000};               // below min normal, flushed
        flg = 4'b0011;
        return;
    end

    sh = lead - `FMA_MAN_W;                    // bits below the kept 11
    if (sh > 0) begin
        keep = mag >> sh;
        rest = mag & ((128'd1 << sh) - 1);
        half = 128'd1 << (sh - 1);
    end else begin
        keep = mag << -sh;
        rest = 128'd0;
        half = 128'd1;                         // never reached by rest
    end
    inexact = (rest != 0);
    case (mode)
        RM_RZ:   up = 1'b0;
        RM_RNE:  up = (rest > half) || (rest == half && keep[0]);
        RM_RDN:  up = rsign & inexact;
        default: up = ~rsign & inexact;
    endcase
    keep = keep + 128'(up);
    if (keep[`FMA_MAN_W+1]) begin              // rounded up to 2.0
        keep = keep >> 1;
        be   = be + 1;
    end

    if (be >= 31) begin
        to_inf = (mode == RM_RNE) || (mode == RM_RUP && !rsign) || (mode == RM_RDN && rsign);
        res    = to_inf ? {rsign, 5'h1f, 10'h000} : {rsign, 15'(`FMA_MAX_FINITE)};
        flg    = 4'b0101;
        return;
    end
    res = {rsign, be[4:0], keep[9:0]};
    flg = {3'b000, inexact};
endfunction

`endif

//--- tests/fma16_tb.sv
// fma16 testbench
// feeds the pipeline through its input handshake, acknowledges results
// after random delays and compares them in order with the reference model
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma16_tb;
    import fma16_pkg::*;

    `include "fma16_ref.svh"

    localparam int TIMEOUT = 200;      // cycles allowed for any one wait

    logic        clk, reset;
    fp16_t       x, y, z;
    logic        mul, add, negp, negz;
    round_mode_t roundmode;
    logic        in_req, in_ack;
    fp16_t       result;
    fp_flags_t   flags;
    logic        out_req, out_ack;

    fp16_t       exp_res_q[$];         // expected values in issue order
    fp_flags_t   exp_flg_q[$];
    logic        producer_done;
    int          cycle = 0;
    int          first_ack = -1;       // cycle at which the first in_ack rose

    fma16_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;         // 8 ns period
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(input fp16_t got, input fp16_t expected);
        if (got !== expected)
            abort_run($sformatf("FAIL at %0t: result expected %h, actual %h",
                                $time, expected, got));
    endtask

    task automatic check_flags(input fp_flags_t got, input fp_flags_t expected);
        if (got !== expected)
            abort_run($sformatf("FAIL at %0t: flags expected %b, actual %b",
                                $time, expected, got));
    endtask

    // inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic fp16_t random_normal();
        fp16_t v;
        v[15]    = 1'($urandom);
        v[14:10] = 5'($urandom_range(21, 8));   // keeps random products finite
        v[9:0]   = 10'($urandom);
        return v;
    endfunction

    //////////////////////////////////////////////////
    // producer
    //////////////////////////////////////////////////
    // opc is {mul, add, negp, negz}
    task automatic send_op(input fp16_t a, b, c, input logic [3:0] opc, input round_mode_t rm);
        fp16_t     r;
        fp_flags_t f;
        int        n;
        fma16_ref(a, b, c, opc[3], opc[2], opc[1], opc[0], rm, r, f);
        exp_res_q.push_back(r);
        exp_flg_q.push_back(f);
        x         = a;
        y         = b;
        z         = c;
        {mul, add, negp, negz} = opc;
        roundmode = rm;
        in_req    = 1'b1;
        for (n = 0; n < TIMEOUT && !in_ack; n++)
            next_cycle();
        if (!in_ack)
            abort_run("timeout: in_ack never rose on the input handshake");
        if (first_ack < 0)
            first_ack = cycle;
        in_req = 1'b0;
        for (n = 0; n < TIMEOUT && in_ack; n++)
            next_cycle();
        if (in_ack)
            abort_run("timeout: in_ack stayed high after in_req fell");
    endtask

    task automatic produce_all();
        round_mode_t rm;
        logic [3:0]  opc;
        int          op;
        send_op(16'h3c00, 16'h4000, 16'h3800, 4'b0000, RM_RNE);   // latency probe 1*2+0.5
        send_op(16'h7d00, 16'h3c00, 16'h3c00, 4'b0000, RM_RNE);   // signaling nan in x
        send_op(16'h3c00, 16'h7e01, 16'h3c00, 4'b0000, RM_RNE);   // quiet nan in y
        send_op(16'h3c00, 16'h3c00, 16'hfc01, 4'b0000, RM_RNE);   // signaling nan in z
        send_op(16'h7c00, 16'h0000, 16'h3c00, 4'b0000, RM_RNE);   // inf * 0
        send_op(16'h0001, 16'hfc00, 16'h3c00, 4'b0000, RM_RUP);   // subnormal * inf
        send_op(16'h7c00, 16'h3c00, 16'hfc00, 4'b0000, RM_RNE);   // +inf - inf
        send_op(16'h7c00, 16'hc000, 16'h3c00, 4'b0000, RM_RZ);    // -inf product
        send_op(16'h3c00, 16'h3c00, 16'hfc00, 4'b0000, RM_RDN);   // -inf addend
        for (int m = 0; m < 4; m++) begin
            rm = round_mode_t'(m);
            send_op(16'h3c00, 16'h4000, 16'hc000, 4'b0000, rm);   // 2 - 2 cancels
            send_op(16'h8000, 16'h3c00, 16'h8000, 4'b0000, rm);   // -0 + -0
            send_op(16'h7800, 16'h4000, 16'h0000, 4'b0000, rm);   // 2^16 overflows
            send_op(16'hf800, 16'h4000, 16'h0000, 4'b0000, rm);   // -2^16 overflows
            send_op(16'h0400, 16'h3800, 16'h0000, 4'b0000, rm);   // 2^-15 flushes
            send_op(16'h8400, 16'h3800, 16'h0000, 4'b0000, rm);
        end
        for (int m = 0; m < 4; m++) begin
            rm = round_mode_t'(m);
            for (int i = 0; i < 80; i++) begin
                op = $urandom_range(5, 0);
                case (op)
                    0: opc = 4'b0000;                              // fmadd
                    1: opc = 4'b0001;                              // fmsub
                    2: opc = 4'b0011;                              // fnmadd
                    3: opc = 4'b0010;                              // fnmsub
                    4: opc = {2'b10, 1'($urandom), 1'b0};          // multiply only
                    default: opc = {2'b01, 1'b0, 1'($urandom)};    // add only
                endcase
                send_op(random_normal(), random_normal(), random_normal(), opc, rm);
            end
        end
        producer_done = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // checker and output acknowledge
    //////////////////////////////////////////////////
    task automatic collect_all();
        fp16_t     held_res;
        fp_flags_t held_flg;
        int        n, delay, count;
        count = 0;
        while (!producer_done || exp_res_q.size() != 0) begin
            for (n = 0; n < TIMEOUT && !out_req; n++)
                next_cycle();
            if (!out_req)
                abort_run("timeout: out_req never rose on the output handshake");
            if (exp_res_q.size() == 0)
                abort_run("a result came out with no operation outstanding");
            if (count == 0 && cycle - first_ack != 3)
                abort_run($sformatf("first result came %0d cycles after in_ack instead of 3",
                                    cycle - first_ack));
            held_res = result;
            held_flg = flags;
            check_result(held_res, exp_res_q.pop_front());
            check_flags(held_flg, exp_flg_q.pop_front());
            delay = (count == 0) ? 0 : $urandom_range(5, 0);   // first ack at once
            repeat (delay) begin
                next_cycle();
                check_result(result, held_res);                // held until acknowledged
                check_flags(flags, held_flg);
            end
            out_ack = 1'b1;
            for (n = 0; n < TIMEOUT && out_req; n++)
                next_cycle();
            if (out_req)
                abort_run("timeout: out_req stayed high after out_ack rose");
            out_ack = 1'b0;
            count++;
        end
    endtask

    initial begin
        void'($urandom(32'h9d91_a965));
        reset         = 1'b1;
        x             = '0;
        y             = '0;
        z             = '0;
        mul           = 1'b0;
        add           = 1'b0;
        negp          = 1'b0;
        negz          = 1'b0;
        roundmode     = RM_RNE;
        in_req        = 1'b0;
        out_ack       = 1'b0;
        producer_done = 1'b0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        if (in_ack !== 1'b0 || out_req !== 1'b0)
            abort_run("in_ack or out_req is not low after reset");
        fork
            produce_all();
            collect_all();
        join
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
+incdir+tests
src/fma16_pkg.sv
src/fma_unpack_stage.sv
src/fma_product_stage.sv
src/fma_sum_stage.sv
src/fma_round_stage.sv
src/fma16_top.sv
tests/fma16_tb.sv

//--- Makefile
# verilator flow for the fma16 pipeline
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module fma16_top -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fma16_tb \
		-f sim.f --Mdir obj_dir -o fma16_sim
	./obj_dir/fma16_sim | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
